// File: Bender.yml
package:
  name: motor_unit

sources:
  - files:
      - logic/motor_pkg.sv
      - logic/step_timing_if.sv
      - logic/step_timer.sv
      - logic/izh_neuron.sv
      - logic/spike_window_counter.sv
      - logic/neural_drive.sv
      - logic/passive_tension.sv
      - logic/muscle_force.sv
      - logic/motor_unit.sv
  - target: simulation
    files:
      - testbench/motor_unit_chk.sv
      - testbench/motor_unit_tb.sv

// File: logic/izh_neuron.sv
`timescale 1ns/1ps

module izh_neuron #(
    parameter int TAU_SHIFT = 2
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_step,
    input  motor_pkg::potential_t i_current,
    output logic                  o_spike
);
    import motor_pkg::*;

    // membrane potential and recovery
    potential_t          v;
    potential_t          u;

    logic signed [35:0]  v_sq_full;
    wide_t               v_w;
    wide_t               u_w;
    wide_t               v_sq;
    wide_t               dv_sum;
    wide_t               v_new;
    wide_t               u_new;
    potential_t          v_sat;
    logic                hit_peak;

    //////////////////////////////////////////////////
    // next-state arithmetic, all from old v and u
    //////////////////////////////////////////////////

    assign v_w = wide_t'(v);
    assign u_w = wide_t'(u);

    // v^2 back to Q2.16
    assign v_sq_full = v * v;
    assign v_sq      = wide_t'(v_sq_full >>> 16);

    // 4v^2 + 1.25v + bias - u + I
    assign dv_sum = (v_sq <<< 2) + v_w + (v_w >>> 2) + wide_t'(IZH_BIAS)
                    - u_w + wide_t'(i_current);
    assign v_new  = v_w + (dv_sum >>> TAU_SHIFT);

    // a * (b*v - u)
    assign u_new = u_w + (((v_w >>> IZH_B_SHIFT) - u_w) >>> IZH_A_SHIFT);

    assign v_sat    = sat_pot(v_new);
    assign hit_peak = (v_sat >= IZH_V_PEAK);

    //////////////////////////////////////////////////
    // state update, only on step clocks
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            v       <= IZH_V_REST;
            u       <= '0;
            o_spike <= 1'b0;
        end else begin
            // single-cycle pulse after the step edge
            o_spike <= i_step && hit_peak;
            if (i_step) begin
                if (hit_peak) begin
                    // fire and jump recovery
                    v <= IZH_C;
                    u <= sat_pot(u_new + wide_t'(IZH_D));
                end else begin
                    v <= v_sat;
                    u <= sat_pot(u_new);
                end
            end
        end
    end

endmodule

// File: logic/motor_pkg.sv
package motor_pkg;

    //////////////////////////////////////////////////
    // fixed-point types
    //////////////////////////////////////////////////

    // Q2.16, potential / recovery / neuron current
    typedef logic signed [17:0] potential_t;
    typedef logic [15:0]        rate_t;
    // Q8.8 rate-to-current coefficient
    typedef logic [15:0]        coef_t;
    typedef logic [7:0]         gain8_t;
    typedef logic [15:0]        count_t;
    typedef logic [15:0]        length_t;
    typedef logic [31:0]        force_t;

    // headroom for neuron sums before saturation
    localparam int WIDE_W = 24;
    typedef logic signed [WIDE_W-1:0] wide_t;

    //////////////////////////////////////////////////
    // timing
    //////////////////////////////////////////////////

    // clocks per neuron step, one per phase
    localparam int STEP_CLKS    = 4;
    localparam int WINDOW_STEPS = 64;
    typedef logic [$clog2(STEP_CLKS)-1:0]    phase_t;
    typedef logic [$clog2(WINDOW_STEPS)-1:0] step_idx_t;

    //////////////////////////////////////////////////
    // neuron and synapse constants
    //////////////////////////////////////////////////

    // a = 0.125, b = 0.25 as shifts
    localparam int IZH_A_SHIFT = 3;
    localparam int IZH_B_SHIFT = 2;
    localparam potential_t IZH_C      = -18'sd42598;  // -0.65
    localparam potential_t IZH_D      = 18'sd5242;    // 0.08
    localparam potential_t IZH_V_PEAK = 18'sd19660;   // 0.30
    localparam potential_t IZH_BIAS   = 18'sd22937;   // 0.35
    localparam potential_t IZH_V_REST = -18'sd45875;  // -0.70
    localparam potential_t POT_MAX    = 18'sh1FFFF;
    localparam potential_t POT_MIN    = -18'sh20000;

    localparam potential_t SYN_WEIGHT      = 18'sh01000;
    localparam int         SYN_DECAY_SHIFT = 3;

    // passive element
    localparam length_t L_SLACK = 16'd1000;
    localparam length_t K_PE    = 16'd12;

    // clamp a wide sum back into Q2.16
    function automatic potential_t sat_pot(input wide_t x);
        if (x > wide_t'(POT_MAX)) begin
            return POT_MAX;
        end else if (x < wide_t'(POT_MIN)) begin
            return POT_MIN;
        end
        return potential_t'(x[17:0]);
    endfunction

endpackage

// File: logic/motor_unit.sv
`timescale 1ns/1ps

module motor_unit (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  motor_pkg::rate_t   i_rate_ia,
    input  motor_pkg::coef_t   i_coef_ia,
    input  motor_pkg::gain8_t  i_gain_mn,
    input  motor_pkg::length_t i_length,
    input  logic [15:0]        i_gain_force,
    output logic               o_ia_spike,
    output logic               o_mn_spike,
    output motor_pkg::count_t  o_spike_count,
    output motor_pkg::force_t  o_force,
    output logic               o_force_valid
);
    import motor_pkg::*;

    logic   count_valid;
    force_t passive;

    // step and window strobes
    step_timing_if tmg ();

    step_timer step_timer_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .tmg     (tmg.timer)
    );

    // active path, spikes to windowed count
    neural_drive neural_drive_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .tmg           (tmg.user),
        .i_rate_ia     (i_rate_ia),
        .i_coef_ia     (i_coef_ia),
        .i_gain_mn     (i_gain_mn),
        .o_ia_spike    (o_ia_spike),
        .o_mn_spike    (o_mn_spike),
        .o_count       (o_spike_count),
        .o_count_valid (count_valid)
    );

    // passive path
    passive_tension passive_tension_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .tmg       (tmg.user),
        .i_length  (i_length),
        .o_passive (passive)
    );

    // total force, two cycles after window end
    muscle_force muscle_force_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_count       (o_spike_count),
        .i_count_valid (count_valid),
        .i_passive     (passive),
        .i_gain_force  (i_gain_force),
        .o_force       (o_force),
        .o_force_valid (o_force_valid)
    );

endmodule

// File: logic/muscle_force.sv
`timescale 1ns/1ps

module muscle_force (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  motor_pkg::count_t i_count,
    input  logic              i_count_valid,
    input  motor_pkg::force_t i_passive,
    input  logic [15:0]       i_gain_force,
    output motor_pkg::force_t o_force,
    output logic              o_force_valid
);
    import motor_pkg::*;

    force_t      active;
    logic [32:0] total;

    // active part from spike count
    assign active = i_count * i_gain_force;
    // carry bit for clipping
    assign total  = {1'b0, active} + {1'b0, i_passive};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_force       <= '0;
            o_force_valid <= 1'b0;
        end else begin
            o_force_valid <= i_count_valid;
            if (i_count_valid) begin
                o_force <= total[32] ? '1 : total[31:0];
            end
        end
    end

endmodule

// File: logic/neural_drive.sv
`timescale 1ns/1ps

module neural_drive (
    input  logic              i_clk,
    input  logic              i_rst_n,
    step_timing_if.user       tmg,
    input  motor_pkg::rate_t  i_rate_ia,
    input  motor_pkg::coef_t  i_coef_ia,
    input  motor_pkg::gain8_t i_gain_mn,
    output logic              o_ia_spike,
    output logic              o_mn_spike,
    output motor_pkg::count_t o_count,
    output logic              o_count_valid
);
    import motor_pkg::*;

    logic [31:0] ia_prod;
    logic [23:0] ia_scaled;
    potential_t  ia_current;
    // synaptic current, never negative
    potential_t  syn;
    logic        syn_pend;
    wide_t       syn_add;
    wide_t       syn_next;
    logic [25:0] mn_prod;
    potential_t  mn_current;

    //////////////////////////////////////////////////
    // Ia afferent
    //////////////////////////////////////////////////

    // rate * Q8.8 coef, drop fraction
    assign ia_prod    = i_rate_ia * i_coef_ia;
    assign ia_scaled  = ia_prod[31:8];
    assign ia_current = (ia_scaled > 24'(POT_MAX)) ? POT_MAX : potential_t'(ia_scaled[17:0]);

    izh_neuron #(.TAU_SHIFT(2)) ia_neuron_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_step    (tmg.o_step),
        .i_current (ia_current),
        .o_spike   (o_ia_spike)
    );

    //////////////////////////////////////////////////
    // synapse, Ia spike to motoneuron current
    //////////////////////////////////////////////////

    // add weight first, then decay
    assign syn_add  = wide_t'(syn) + (syn_pend ? wide_t'(SYN_WEIGHT) : wide_t'(0));
    assign syn_next = syn_add - (syn_add >>> SYN_DECAY_SHIFT);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            syn      <= '0;
            syn_pend <= 1'b0;
        end else begin
            // spike arrives between steps, hold until the next one
            syn_pend <= (syn_pend && !tmg.o_step) || o_ia_spike;
            if (tmg.o_step) begin
                syn <= sat_pot(syn_next);
            end
        end
    end

    // syn * gain, clipped to Q2.16
    assign mn_prod    = {8'd0, syn} * {18'd0, i_gain_mn};
    assign mn_current = (mn_prod > 26'(POT_MAX)) ? POT_MAX : potential_t'(mn_prod[17:0]);

    //////////////////////////////////////////////////
    // motoneuron and spike count
    //////////////////////////////////////////////////

    izh_neuron #(.TAU_SHIFT(2)) mn_neuron_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_step    (tmg.o_step),
        .i_current (mn_current),
        .o_spike   (o_mn_spike)
    );

    spike_window_counter counter_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .tmg           (tmg),
        .i_spike       (o_mn_spike),
        .o_count       (o_count),
        .o_count_valid (o_count_valid)
    );

endmodule

// File: logic/passive_tension.sv
`timescale 1ns/1ps

module passive_tension (
    input  logic               i_clk,
    input  logic               i_rst_n,
    step_timing_if.user        tmg,
    input  motor_pkg::length_t i_length,
    output motor_pkg::force_t  o_passive
);
    import motor_pkg::*;

    // stretch beyond slack, zero when slack
    length_t stretch;
    force_t  pe_force;

    assign stretch  = (i_length > L_SLACK) ? i_length - L_SLACK : '0;
    assign pe_force = stretch * K_PE;

    // one sample per window
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_passive <= '0;
        end else if (tmg.o_window_end) begin
            o_passive <= pe_force;
        end
    end

endmodule

// File: logic/spike_window_counter.sv
`timescale 1ns/1ps

module spike_window_counter (
    input  logic              i_clk,
    input  logic              i_rst_n,
    step_timing_if.user       tmg,
    input  logic              i_spike,
    output motor_pkg::count_t o_count,
    output logic              o_count_valid
);
    import motor_pkg::*;

    // running count for the current window
    count_t cnt;
    count_t cnt_inc;

    // saturate at all ones
    assign cnt_inc = (i_spike && (cnt != '1)) ? cnt + 1'b1 : cnt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt           <= '0;
            o_count       <= '0;
            o_count_valid <= 1'b0;
        end else begin
            o_count_valid <= tmg.o_window_end;
            if (tmg.o_window_end) begin
                // hand over window result, restart
                o_count <= cnt_inc;
                cnt     <= '0;
            end else begin
                cnt <= cnt_inc;
            end
        end
    end

endmodule

// File: logic/step_timer.sv
`timescale 1ns/1ps

module step_timer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    step_timing_if.timer       tmg
);
    import motor_pkg::*;

    // clock phase inside a step
    phase_t    phase;
    // next step number inside the window
    step_idx_t step_cnt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase              <= '0;
            step_cnt           <= '0;
            tmg.o_step         <= 1'b0;
            tmg.o_window_start <= 1'b0;
            tmg.o_window_end   <= 1'b0;
            tmg.o_step_idx     <= '0;
        end else begin
            // strobes default low
            tmg.o_step         <= 1'b0;
            tmg.o_window_start <= 1'b0;
            tmg.o_window_end   <= 1'b0;
            if (phase == phase_t'(STEP_CLKS - 1)) begin
                phase              <= '0;
                tmg.o_step         <= 1'b1;
                tmg.o_step_idx     <= step_cnt;
                tmg.o_window_start <= (step_cnt == '0);
                tmg.o_window_end   <= (step_cnt == step_idx_t'(WINDOW_STEPS - 1));
                // wraps into the next window
                step_cnt           <= step_cnt + 1'b1;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

// File: logic/step_timing_if.sv
`timescale 1ns/1ps

interface step_timing_if;
    import motor_pkg::*;

    // one-cycle strobes, all from the step timer
    logic      o_step;
    logic      o_window_start;
    logic      o_window_end;
    // index of the step being strobed
    step_idx_t o_step_idx;

    modport timer (
        output o_step, o_window_start, o_window_end, o_step_idx
    );

    modport user (
        input o_step, o_window_start, o_window_end, o_step_idx
    );

endinterface

// File: sources.f
logic/motor_pkg.sv
logic/step_timing_if.sv
logic/step_timer.sv
logic/izh_neuron.sv
logic/spike_window_counter.sv
logic/neural_drive.sv
logic/passive_tension.sv
logic/muscle_force.sv
logic/motor_unit.sv
testbench/motor_unit_chk.sv
testbench/motor_unit_tb.sv

// File: testbench/motor_unit_chk.sv
`timescale 1ns/1ps

module motor_unit_chk (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_window_end,
    input  logic i_ia_spike,
    input  logic i_mn_spike,
    input  logic i_force_valid
);

    // number of failed assertions so far
    int fail_count = 0;

    //////////////////////////////////////////////////
    // force timing against the window strobe
    //////////////////////////////////////////////////

    // count latch and then force after a window end
    a_force_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_window_end |-> ##2 i_force_valid)
        else begin
            $error("force valid missing two cycles after window end");
            fail_count++;
        end

    // no force without a window end before it
    a_force_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_force_valid |-> $past(i_window_end, 2))
        else begin
            $error("force valid without a window end two cycles earlier");
            fail_count++;
        end

    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_force_valid |=> !i_force_valid)
        else begin
            $error("force valid held longer than one cycle");
            fail_count++;
        end

    // spikes quiet once reset has taken hold
    a_reset_quiet: assert property (@(posedge i_clk)
        (!i_rst_n ##1 !i_rst_n) |-> (!i_ia_spike && !i_mn_spike))
        else begin
            $error("spike output high during reset");
            fail_count++;
        end

endmodule

bind motor_unit motor_unit_chk motor_unit_chk_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_window_end  (tmg.o_window_end),
    .i_ia_spike    (o_ia_spike),
    .i_mn_spike    (o_mn_spike),
    .i_force_valid (o_force_valid)
);

// File: testbench/motor_unit_tb.sv
`timescale 1ns/1ps

module motor_unit_tb;
    import motor_pkg::*;

    localparam int          N_WINDOWS   = 30;
    localparam int          CYCLE_LIMIT = N_WINDOWS * STEP_CLKS * WINDOW_STEPS + 200;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

    logic        i_clk;
    logic        i_rst_n;
    rate_t       i_rate_ia;
    coef_t       i_coef_ia;
    gain8_t      i_gain_mn;
    length_t     i_length;
    logic [15:0] i_gain_force;
    logic        o_ia_spike;
    logic        o_mn_spike;
    count_t      o_spike_count;
    force_t      o_force;
    logic        o_force_valid;

    // expected results per window
    count_t exp_count_q[$];
    force_t exp_force_q[$];
    int     exp_ia_q[$];
    int     exp_mn_q[$];

    int          errors;
    int          checks;
    int          tests_run;
    int          cycles;
    int          ia_seen;
    int          mn_seen;
    logic [31:0] lfsr;

    // model state kept across windows
    longint m_ia_v;
    longint m_ia_u;
    longint m_mn_v;
    longint m_mn_u;
    longint m_syn;
    bit     m_pend;
    bit     m_mn_carry;

    motor_unit motor_unit_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rate_ia     (i_rate_ia),
        .i_coef_ia     (i_coef_ia),
        .i_gain_mn     (i_gain_mn),
        .i_length      (i_length),
        .i_gain_force  (i_gain_force),
        .o_ia_spike    (o_ia_spike),
        .o_mn_spike    (o_mn_spike),
        .o_spike_count (o_spike_count),
        .o_force       (o_force),
        .o_force_valid (o_force_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic longint clamp_q16(input longint x);
        if (x > longint'(POT_MAX)) begin
            return longint'(POT_MAX);
        end else if (x < longint'(POT_MIN)) begin
            return longint'(POT_MIN);
        end
        return x;
    endfunction

    // one Izhikevich step using the old v in both equations
    function automatic bit neuron_step(inout longint v, inout longint u,
                                       input longint cur, input int tau);
        longint v_sq;
        longint dv;
        longint v_next;
        longint u_next;
        v_sq   = (v * v) >>> 16;
        dv     = 4 * v_sq + v + (v >>> 2) + longint'(IZH_BIAS) - u + cur;
        v_next = clamp_q16(v + (dv >>> tau));
        u_next = u + (((v >>> IZH_B_SHIFT) - u) >>> IZH_A_SHIFT);
        if (v_next >= longint'(IZH_V_PEAK)) begin
            v = longint'(IZH_C);
            u = clamp_q16(u_next + longint'(IZH_D));
            return 1'b1;
        end
        v = v_next;
        u = clamp_q16(u_next);
        return 1'b0;
    endfunction

    // 64 steps of both neurons and the synapse
    function automatic force_t model_window(input rate_t rate, input coef_t coef,
                                            input gain8_t gmn, input length_t len,
                                            input logic [15:0] gf, output count_t cnt,
                                            output int ia_tot, output int mn_tot);
        longint ia_cur;
        longint mn_cur;
        longint syn_add;
        longint passive;
        longint total;
        bit     ia_spk;
        bit     mn_spk;
        int     mn_cnt;
        ia_cur = (longint'(rate) * longint'(coef)) >>> 8;
        if (ia_cur > longint'(POT_MAX)) begin
            ia_cur = longint'(POT_MAX);
        end
        // spike of last window's final step lands here
        mn_cnt = m_mn_carry;
        ia_tot = 0;
        mn_tot = 0;
        for (int s = 0; s < WINDOW_STEPS; s++) begin
            // motoneuron sees synapse from the previous step
            mn_cur = m_syn * longint'(gmn);
            if (mn_cur > longint'(POT_MAX)) begin
                mn_cur = longint'(POT_MAX);
            end
            syn_add = m_syn + (m_pend ? longint'(SYN_WEIGHT) : 64'sd0);
            m_syn   = clamp_q16(syn_add - (syn_add >>> SYN_DECAY_SHIFT));
            ia_spk  = neuron_step(m_ia_v, m_ia_u, ia_cur, 2);
            mn_spk  = neuron_step(m_mn_v, m_mn_u, mn_cur, 2);
            m_pend  = ia_spk;
            ia_tot += ia_spk;
            mn_tot += mn_spk;
            if (s < WINDOW_STEPS - 1) begin
                mn_cnt += mn_spk;
            end else begin
                m_mn_carry = mn_spk;
            end
        end
        cnt = (mn_cnt > 65535) ? 16'hFFFF : count_t'(mn_cnt);
        passive = 0;
        if (len > L_SLACK) begin
            passive = (longint'(len) - longint'(L_SLACK)) * longint'(K_PE);
        end
        total = longint'(cnt) * longint'(gf) + passive;
        if (total > 64'sh0_FFFF_FFFF) begin
            return '1;
        end
        return force_t'(total);
    endfunction

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        bit          b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_force(input string name, input force_t got, input force_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_spikes(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // drive one window and queue its expected result
    task automatic run_window(input rate_t rate, input coef_t coef, input gain8_t gmn,
                              input length_t len, input logic [15:0] gf);
        count_t c;
        force_t f;
        int     ia_t;
        int     mn_t;
        i_rate_ia    = rate;
        i_coef_ia    = coef;
        i_gain_mn    = gmn;
        i_length     = len;
        i_gain_force = gf;
        f = model_window(rate, coef, gmn, len, gf, c, ia_t, mn_t);
        exp_count_q.push_back(c);
        exp_force_q.push_back(f);
        exp_ia_q.push_back(ia_t);
        exp_mn_q.push_back(mn_t);
        do begin
            @(posedge i_clk);
            #1;
        end while (!o_force_valid);
        // next drive lands in the cycle after the valid
        @(posedge i_clk);
        #1;
    endtask

    task automatic report_test(input string name, input int n_win, input int err_before);
        tests_run++;
        $display("test %s: %0d windows, %0d errors", name, n_win, errors - err_before);
    endtask

    //////////////////////////////////////////////////
    // compare process for each force valid
    //////////////////////////////////////////////////

    initial begin : compare_proc
        forever begin
            @(posedge i_clk);
            #1;
            if (o_ia_spike === 1'b1) begin
                ia_seen++;
            end
            if (o_mn_spike === 1'b1) begin
                mn_seen++;
            end
            if (o_force_valid === 1'b1) begin
                if (exp_force_q.size() == 0) begin
                    errors++;
                    $display("force valid at %0t with no window expected", $time);
                end else begin
                    check_count("o_spike_count", o_spike_count, exp_count_q.pop_front());
                    check_force("o_force", o_force, exp_force_q.pop_front());
                    check_spikes("o_ia_spike total", ia_seen, exp_ia_q.pop_front());
                    check_spikes("o_mn_spike total", mn_seen, exp_mn_q.pop_front());
                end
                ia_seen = 0;
                mn_seen = 0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin : stimulus
        int err_before;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        ia_seen      = 0;
        mn_seen      = 0;
        lfsr         = 32'h12b51672;
        i_rst_n      = 1'b0;
        i_rate_ia    = '0;
        i_coef_ia    = '0;
        i_gain_mn    = '0;
        i_length     = '0;
        i_gain_force = '0;
        m_ia_v       = longint'(IZH_V_REST);
        m_ia_u       = 0;
        m_mn_v       = longint'(IZH_V_REST);
        m_mn_u       = 0;
        m_syn        = 0;
        m_pend       = 1'b0;
        m_mn_carry   = 1'b0;

        // reset and a few cycles before the first step
        err_before = errors;
        for (int i = 0; i < 19; i++) begin
            @(posedge i_clk);
            #1;
            if (i == 15) begin
                i_rst_n = 1'b1;
            end
            check_force("o_force", o_force, '0);
            check_flag("o_force_valid", o_force_valid, 1'b0);
            check_flag("o_ia_spike", o_ia_spike, 1'b0);
            check_flag("o_mn_spike", o_mn_spike, 1'b0);
        end
        report_test("reset", 0, err_before);

        // no afferent current with length below, at and above slack
        err_before = errors;
        run_window(16'd0, 16'h0100, 8'd16, 16'd900, 16'd100);
        run_window(16'd0, 16'h0100, 8'd16, 16'd1000, 16'd100);
        run_window(16'd0, 16'h0100, 8'd16, 16'd1100, 16'd100);
        report_test("zero drive", 3, err_before);

        err_before = errors;
        for (int w = 0; w < 4; w++) begin
            run_window(16'd200, 16'h4000, 8'd4, 16'd1200, 16'd250);
        end
        report_test("constant drive", 4, err_before);

        // both currents pinned at the top
        err_before = errors;
        for (int w = 0; w < 3; w++) begin
            run_window(16'hFFFF, 16'hFFFF, 8'hFF, 16'hFFFF, 16'hFFFF);
        end
        report_test("saturation", 3, err_before);

        err_before = errors;
        for (int w = 0; w < 20; w++) begin
            run_window(rate_t'(rand_bits(16)), coef_t'(rand_bits(16)),
                       gain8_t'(rand_bits(8)), length_t'(16'd400 + rand_bits(11)),
                       16'(rand_bits(16)));
        end
        report_test("random windows", 20, err_before);

        if (exp_force_q.size() != 0) begin
            errors++;
            $display("%0d windows never produced a force result", exp_force_q.size());
        end
        if (motor_unit_inst.motor_unit_chk_inst.fail_count != 0) begin
            errors += motor_unit_inst.motor_unit_chk_inst.fail_count;
            $display("%0d timing assertions failed",
                     motor_unit_inst.motor_unit_chk_inst.fail_count);
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
